//--- hw/fu_pkg.sv
`default_nettype none

package fu_pkg;

    //////////////////////////////////////////////////////////////////////
    // unit categories and operations
    //////////////////////////////////////////////////////////////////////

    typedef enum logic {
        kind_alu  = 1'b0,
        kind_mult = 1'b1
    } fu_kind_t;

    // alu codes first, multiplier after
    typedef enum logic [3:0] {
        op_add = 4'd0,
        op_sub = 4'd1,
        op_and = 4'd2,
        op_or  = 4'd3,
        op_xor = 4'd4,
        op_slt = 4'd5,
        op_sll = 4'd6,
        op_srl = 4'd7,
        op_mul = 4'd8
    } fu_op_t;

    //////////////////////////////////////////////////////////////////////
    // result held in a unit until it wins the bus
    //////////////////////////////////////////////////////////////////////

    // same layout as the broadcast word
    typedef struct packed {
        logic        valid;
        logic [4:0]  tag;
        logic [31:0] value;
    } fu_result_t;

endpackage

`default_nettype wire

//--- hw/rs_pkg.sv
`default_nettype none

package rs_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////////////////////////

    localparam int tag_w = 5;
    localparam int xlen  = 32;

    typedef logic [tag_w-1:0] tag_t;
    typedef logic [xlen-1:0]  value_t;

    //////////////////////////////////////////////////////////////////////
    // station words
    //////////////////////////////////////////////////////////////////////

    // value is meaningful once ready, tag until then
    typedef struct packed {
        tag_t   tag;
        value_t value;
        logic   ready;
    } operand_t;

    // unused sources come in ready with zero value
    typedef struct packed {
        logic             valid;
        fu_pkg::fu_kind_t kind;
        fu_pkg::fu_op_t   op;
        tag_t             dest;
        operand_t         src1;
        operand_t         src2;
    } dispatch_t;

    // one result per cycle at most
    typedef struct packed {
        logic   valid;
        tag_t   tag;
        value_t value;
    } cdb_t;

endpackage

`default_nettype wire

//--- hw/alu_unit.sv
`default_nettype none

module alu_unit (
    input  logic               clock,
    input  logic               reset,
    input  logic               squash,
    input  logic               issue,
    input  fu_pkg::fu_op_t     op,
    input  rs_pkg::tag_t       tag,
    input  rs_pkg::value_t     a,
    input  rs_pkg::value_t     b,
    input  logic               grant,
    output fu_pkg::fu_result_t result
);
    import rs_pkg::*;
    import fu_pkg::*;

    value_t alu_out;
    logic   held_valid;
    tag_t   held_tag;
    value_t held_value;

    always_comb begin
        case (op)
            op_add:  alu_out = a + b;
            op_sub:  alu_out = a - b;
            op_and:  alu_out = a & b;
            op_or:   alu_out = a | b;
            op_xor:  alu_out = a ^ b;
            op_slt:  alu_out = value_t'($signed(a) < $signed(b));
            op_sll:  alu_out = a << b[4:0];
            op_srl:  alu_out = a >> b[4:0];
            default: alu_out = '0;
        endcase
    end

    // held until the arbiter picks it
    always_ff @(posedge clock) begin
        if (reset || squash) begin
            held_valid <= 1'b0;
        end else if (issue) begin
            held_valid <= 1'b1;
        end else if (grant) begin
            held_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (issue) begin
            held_tag   <= tag;
            held_value <= alu_out;
        end
    end

    assign result = '{valid: held_valid, tag: held_tag, value: held_value};

    // entry issues once and frees only on grant
    a_no_issue_while_held: assert property (@(posedge clock) disable iff (reset)
        issue |-> !held_valid);

endmodule

`default_nettype wire

//--- hw/mult_unit.sv
`default_nettype none

module mult_unit #(
    parameter int mult_stages = 3
) (
    input  logic               clock,
    input  logic               reset,
    input  logic               squash,
    input  logic               issue,
    input  fu_pkg::fu_op_t     op,
    input  rs_pkg::tag_t       tag,
    input  rs_pkg::value_t     a,
    input  rs_pkg::value_t     b,
    input  logic               grant,
    output fu_pkg::fu_result_t result
);
    import rs_pkg::*;
    import fu_pkg::*;

    localparam int last = mult_stages - 1;

    logic [mult_stages-1:0] stage_valid;
    tag_t                   stage_tag  [mult_stages];
    value_t                 stage_prod [mult_stages];
    value_t                 product;
    logic                   occupied;

    // low word of the product
    assign product  = (op == op_mul) ? a * b : '0;
    assign occupied = |stage_valid;

    //////////////////////////////////////////////////////////////////////
    // pipeline, last stage doubles as the held result
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            stage_valid <= '0;
        end else begin
            stage_valid[0] <= issue;
            for (int i = 1; i < mult_stages; i++) begin
                stage_valid[i] <= stage_valid[i-1];
            end
            // hold at the end until granted
            if (stage_valid[last] && !grant) begin
                stage_valid[last] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (issue) begin
            stage_tag[0]  <= tag;
            stage_prod[0] <= product;
        end
        for (int i = 1; i < mult_stages; i++) begin
            if (stage_valid[i-1]) begin
                stage_tag[i]  <= stage_tag[i-1];
                stage_prod[i] <= stage_prod[i-1];
            end
        end
    end

    assign result = '{
        valid: stage_valid[last],
        tag:   stage_tag[last],
        value: stage_prod[last]
    };

    // one operation at a time, from issue until its broadcast
    a_no_issue_while_busy: assert property (@(posedge clock) disable iff (reset)
        issue |-> !occupied);

endmodule

`default_nettype wire

//--- hw/rs_bank.sv
`default_nettype none

module rs_bank #(
    parameter int               entries     = 4,
    parameter fu_pkg::fu_kind_t kind        = fu_pkg::kind_alu,
    parameter int               mult_stages = 3
) (
    input  logic                              clock,
    input  logic                              reset,
    input  logic                              squash,
    input  rs_pkg::dispatch_t                 dispatch,
    input  rs_pkg::cdb_t                      cdb,
    input  logic               [entries-1:0]  grant,
    output fu_pkg::fu_result_t [entries-1:0]  results,
    output logic                              full
);
    import rs_pkg::*;
    import fu_pkg::*;

    typedef struct packed {
        tag_t     dest;
        fu_op_t   op;
        operand_t src1;
        operand_t src2;
    } entry_t;

    entry_t             entry [entries];
    logic [entries-1:0] busy;
    logic [entries-1:0] issued;
    logic [entries-1:0] alloc;
    logic [entries-1:0] issue;
    logic [entries-1:0] busy_next;
    logic [entries-1:0] result_valid;
    logic               accept;

    // capture a broadcast value for a waiting operand
    function automatic operand_t wake(operand_t src, cdb_t bus);
        operand_t woken;
        woken = src;
        if (!src.ready && bus.valid && src.tag == bus.tag) begin
            woken.value = bus.value;
            woken.ready = 1'b1;
        end
        return woken;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // allocation
    //////////////////////////////////////////////////////////////////////

    assign accept = dispatch.valid && dispatch.kind == kind && !full;

    // lowest free entry, freed entries wait a cycle
    always_comb begin
        logic found;
        found = 1'b0;
        alloc = '0;
        for (int i = 0; i < entries; i++) begin
            if (accept && !busy[i] && !found) begin
                alloc[i] = 1'b1;
                found    = 1'b1;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < entries; i++) begin
            issue[i]        = busy[i] && !issued[i] && entry[i].src1.ready
                              && entry[i].src2.ready;
            result_valid[i] = results[i].valid;
        end
        busy_next = (busy & ~grant) | alloc;
    end

    //////////////////////////////////////////////////////////////////////
    // entry state
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            busy   <= '0;
            issued <= '0;
            full   <= 1'b0;
        end else begin
            busy   <= busy_next;
            issued <= (issued | issue) & ~grant & ~alloc;
            full   <= &busy_next;
        end
    end

    // wakeup also covers the operands being written
    always_ff @(posedge clock) begin
        for (int i = 0; i < entries; i++) begin
            if (alloc[i]) begin
                entry[i] <= '{
                    dest: dispatch.dest,
                    op:   dispatch.op,
                    src1: wake(dispatch.src1, cdb),
                    src2: wake(dispatch.src2, cdb)
                };
            end else begin
                entry[i].src1 <= wake(entry[i].src1, cdb);
                entry[i].src2 <= wake(entry[i].src2, cdb);
            end
        end
    end

    // one unit per entry
    for (genvar i = 0; i < entries; i++) begin : g_unit
        if (kind == kind_alu) begin : g_alu
            alu_unit alu_i (
                .clock  (clock),
                .reset  (reset),
                .squash (squash),
                .issue  (issue[i]),
                .op     (entry[i].op),
                .tag    (entry[i].dest),
                .a      (entry[i].src1.value),
                .b      (entry[i].src2.value),
                .grant  (grant[i]),
                .result (results[i])
            );
        end else begin : g_mult
            mult_unit #(
                .mult_stages (mult_stages)
            ) mult_i (
                .clock  (clock),
                .reset  (reset),
                .squash (squash),
                .issue  (issue[i]),
                .op     (entry[i].op),
                .tag    (entry[i].dest),
                .a      (entry[i].src1.value),
                .b      (entry[i].src2.value),
                .grant  (grant[i]),
                .result (results[i])
            );
        end
    end

    a_grant_only_held: assert property (@(posedge clock) disable iff (reset)
        (grant & ~result_valid) == '0);

    // an offer while full leaves the entries untouched
    a_no_alloc_full: assert property (@(posedge clock) disable iff (reset)
        (dispatch.valid && dispatch.kind == kind && full && !squash)
        |=> busy == $past(busy & ~grant));

endmodule

`default_nettype wire

//--- hw/cdb_arbiter.sv
`default_nettype none

module cdb_arbiter #(
    parameter int num_alu  = 4,
    parameter int num_mult = 2
) (
    input  logic                               clock,
    input  logic                               reset,
    input  fu_pkg::fu_result_t [num_alu-1:0]   alu_results,
    input  fu_pkg::fu_result_t [num_mult-1:0]  mult_results,
    output logic               [num_alu-1:0]   alu_grant,
    output logic               [num_mult-1:0]  mult_grant,
    output rs_pkg::cdb_t                       cdb
);
    import fu_pkg::*;

    localparam int units = num_alu + num_mult;
    localparam int ptr_w = (units > 1) ? $clog2(units) : 1;

    fu_result_t [units-1:0] ring;
    logic       [units-1:0] grant;
    logic       [ptr_w-1:0] ptr;
    logic       [ptr_w-1:0] sel;

    // alus occupy the low slots of the ring
    assign ring = {mult_results, alu_results};

    // walk backwards so the slot nearest the pointer wins
    always_comb begin
        int idx;
        grant = '0;
        sel   = '0;
        for (int k = units - 1; k >= 0; k--) begin
            idx = (int'(ptr) + k) % units;
            if (ring[idx].valid) begin
                grant      = '0;
                grant[idx] = 1'b1;
                sel        = ptr_w'(idx);
            end
        end
    end

    always_comb begin
        cdb = '0;
        if (|grant) begin
            cdb.valid = 1'b1;
            cdb.tag   = ring[sel].tag;
            cdb.value = ring[sel].value;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            ptr <= '0;
        end else if (|grant) begin
            ptr <= (int'(sel) == units - 1) ? '0 : sel + 1'b1;
        end
    end

    assign alu_grant  = grant[num_alu-1:0];
    assign mult_grant = grant[units-1:num_alu];

    a_one_grant: assert property (@(posedge clock) disable iff (reset)
        $onehot0(grant));

endmodule

`default_nettype wire

//--- hw/rs_top.sv
`default_nettype none

module rs_top #(
    parameter int num_alu     = 4,
    parameter int num_mult    = 2,
    parameter int mult_stages = 3
) (
    input  logic              clock,
    input  logic              reset,
    input  logic              squash,
    input  rs_pkg::dispatch_t dispatch,
    output logic              alu_full,
    output logic              mult_full,
    output rs_pkg::cdb_t      cdb
);
    import fu_pkg::*;

    fu_result_t [num_alu-1:0]  alu_results;
    fu_result_t [num_mult-1:0] mult_results;
    logic       [num_alu-1:0]  alu_grant;
    logic       [num_mult-1:0] mult_grant;

    //////////////////////////////////////////////////////////////////////
    // one bank per category, both see every dispatch
    //////////////////////////////////////////////////////////////////////

    rs_bank #(
        .entries     (num_alu),
        .kind        (kind_alu),
        .mult_stages (mult_stages)
    ) alu_bank_i (
        .clock    (clock),
        .reset    (reset),
        .squash   (squash),
        .dispatch (dispatch),
        .cdb      (cdb),
        .grant    (alu_grant),
        .results  (alu_results),
        .full     (alu_full)
    );

    rs_bank #(
        .entries     (num_mult),
        .kind        (kind_mult),
        .mult_stages (mult_stages)
    ) mult_bank_i (
        .clock    (clock),
        .reset    (reset),
        .squash   (squash),
        .dispatch (dispatch),
        .cdb      (cdb),
        .grant    (mult_grant),
        .results  (mult_results),
        .full     (mult_full)
    );

    // result bus, fed back to both banks for wakeup
    cdb_arbiter #(
        .num_alu  (num_alu),
        .num_mult (num_mult)
    ) cdb_arbiter_i (
        .clock        (clock),
        .reset        (reset),
        .alu_results  (alu_results),
        .mult_results (mult_results),
        .alu_grant    (alu_grant),
        .mult_grant   (mult_grant),
        .cdb          (cdb)
    );

endmodule

`default_nettype wire

//--- verif/tb_rs_checks.sv
`default_nettype none

module tb_rs_checks #(
    parameter int num_alu     = 4,
    parameter int num_mult    = 2,
    parameter int mult_stages = 3
) (
    input logic         clock,
    input logic         reset,
    input logic         squash,
    input logic         alu_full,
    input logic         mult_full,
    input rs_pkg::cdb_t cdb
);
    timeunit 1ns;
    timeprecision 100ps;

    //////////////////////////////////////////////////////////////////////
    // reset and squash leave the station empty
    //////////////////////////////////////////////////////////////////////

    a_clear: assert property (@(posedge clock)
        (reset || squash) |=> (!cdb.valid && !alu_full && !mult_full))
        else begin
            $error("outputs not cleared after reset or squash");
            tb_rs.failed = 1'b1;
        end

    //////////////////////////////////////////////////////////////////////
    // broadcasts
    //////////////////////////////////////////////////////////////////////

    // only live tags, so each one at most once and none after squash
    a_tag_live: assert property (@(posedge clock) disable iff (reset)
        cdb.valid |-> tb_rs.pending[cdb.tag])
        else begin
            $error("broadcast of tag %0d which is not in flight", cdb.tag);
            tb_rs.failed = 1'b1;
        end

    a_value: assert property (@(posedge clock) disable iff (reset)
        cdb.valid |-> cdb.value == tb_rs.exp_value[cdb.tag])
        else begin
            $error("at %0t ns: tag %0d value %h, expected %h",
                   $time, cdb.tag, cdb.value, tb_rs.exp_value[cdb.tag]);
            tb_rs.failed = 1'b1;
        end

    a_latency: assert property (@(posedge clock) disable iff (reset)
        cdb.valid |-> (tb_rs.cycle - tb_rs.disp_cycle[cdb.tag])
                      >= (tb_rs.is_mult[cdb.tag] ? mult_stages + 1 : 2))
        else begin
            $error("at %0t ns: tag %0d broadcast too early", $time, cdb.tag);
            tb_rs.failed = 1'b1;
        end

    // consumer never ahead of a producer still in flight
    a_order: assert property (@(posedge clock) disable iff (reset)
        cdb.valid |-> !(tb_rs.dep1[cdb.tag] && tb_rs.pending[tb_rs.prod1[cdb.tag]])
                   && !(tb_rs.dep2[cdb.tag] && tb_rs.pending[tb_rs.prod2[cdb.tag]]))
        else begin
            $error("tag %0d broadcast before its producer", cdb.tag);
            tb_rs.failed = 1'b1;
        end

    //////////////////////////////////////////////////////////////////////
    // full levels follow the outstanding counts
    //////////////////////////////////////////////////////////////////////

    a_alu_full: assert property (@(posedge clock) disable iff (reset)
        alu_full == (tb_rs.alu_count == num_alu))
        else begin
            $error("alu_full does not match outstanding ALU instructions");
            tb_rs.failed = 1'b1;
        end

    a_mult_full: assert property (@(posedge clock) disable iff (reset)
        mult_full == (tb_rs.mult_count == num_mult))
        else begin
            $error("mult_full does not match outstanding multiplies");
            tb_rs.failed = 1'b1;
        end

endmodule

`default_nettype wire

//--- verif/tb_rs.sv
`default_nettype none

module tb_rs;
    timeunit 1ns;
    timeprecision 100ps;

    import rs_pkg::*;
    import fu_pkg::*;

    localparam int num_alu     = 4;
    localparam int num_mult    = 2;
    localparam int mult_stages = 3;
    localparam int steps       = 1000;
    localparam int cycle_limit = 4000;

    logic      clock;
    logic      reset;
    logic      squash;
    dispatch_t dispatch;
    logic      alu_full;
    logic      mult_full;
    cdb_t      cdb;

    // expected state per tag
    logic   pending    [32];
    value_t exp_value  [32];
    int     disp_cycle [32];
    logic   is_mult    [32];
    logic   dep1       [32];
    logic   dep2       [32];
    tag_t   prod1      [32];
    tag_t   prod2      [32];
    int     alu_count;
    int     mult_count;
    int     cycle  = 0;
    logic   failed = 1'b0;
    integer seed;
    cdb_t   last_cdb;
    tag_t   next_tag;
    tag_t   last_tag;

    rs_top #(
        .num_alu     (num_alu),
        .num_mult    (num_mult),
        .mult_stages (mult_stages)
    ) dut_i (
        .clock     (clock),
        .reset     (reset),
        .squash    (squash),
        .dispatch  (dispatch),
        .alu_full  (alu_full),
        .mult_full (mult_full),
        .cdb       (cdb)
    );

    bind rs_top tb_rs_checks #(
        .num_alu     (num_alu),
        .num_mult    (num_mult),
        .mult_stages (mult_stages)
    ) checks_i (.*);

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle <= cycle + 1;
        if (cycle >= cycle_limit) begin
            $display("timeout: results still outstanding after %0d cycles", cycle);
            $display("SOME TESTS FAILED");
            $fatal(1, "run stopped by timeout");
        end
    end

    initial begin
        wait (failed === 1'b1);
        $display("SOME TESTS FAILED");
        $fatal(1, "check failed");
    end

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    function automatic value_t result_of(fu_op_t op, value_t a, value_t b);
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            op_sll:  return a << b[4:0];
            op_srl:  return a >> b[4:0];
            default: return a * b;
        endcase
    endfunction

    task automatic clear_all();
        for (int i = 0; i < 32; i++) begin
            pending[i] = 1'b0;
            dep1[i]    = 1'b0;
            dep2[i]    = 1'b0;
        end
        alu_count  = 0;
        mult_count = 0;
    endtask

    // the broadcast of the edge just passed
    task automatic retire(input cdb_t bus);
        if (bus.valid && pending[bus.tag]) begin
            pending[bus.tag] = 1'b0;
            if (is_mult[bus.tag])
                mult_count--;
            else
                alu_count--;
            for (int i = 0; i < 32; i++) begin
                if (dep1[i] && prod1[i] == bus.tag)
                    dep1[i] = 1'b0;
                if (dep2[i] && prod2[i] == bus.tag)
                    dep2[i] = 1'b0;
            end
        end
    endtask

    // outstanding from the edge that accepted it, dropped offers are not pending
    task automatic count_accepted();
        if (dispatch.valid && pending[dispatch.dest]) begin
            if (dispatch.kind == kind_mult)
                mult_count++;
            else
                alu_count++;
        end
    endtask

    // waits on the bus tag (bypass), the newest tag, or is a ready value
    task automatic make_source(output operand_t src, output value_t v,
                               output logic dep, output tag_t prod);
        int pick;
        pick = $random(seed) & 3;
        dep  = 1'b0;
        prod = '0;
        v    = $random(seed);
        src  = '{tag: '0, value: v, ready: 1'b1};
        if (pick == 0 && cdb.valid && pending[cdb.tag]) begin
            prod = cdb.tag;
            dep  = 1'b1;
        end else if (pick == 1 && pending[last_tag]) begin
            prod = last_tag;
            dep  = 1'b1;
        end
        if (dep) begin
            v   = exp_value[prod];
            src = '{tag: prod, value: '0, ready: 1'b0};
        end
    endtask

    task automatic offer(input fu_kind_t k, input logic record);
        operand_t s1;
        operand_t s2;
        value_t   v1;
        value_t   v2;
        logic     d1;
        logic     d2;
        tag_t     p1;
        tag_t     p2;
        tag_t     t;
        fu_op_t   op;
        make_source(s1, v1, d1, p1);
        make_source(s2, v2, d2, p2);
        op = (k == kind_mult) ? op_mul : fu_op_t'($random(seed) & 7);
        while (pending[next_tag])
            next_tag++;
        t = next_tag;
        next_tag++;
        dispatch = '{valid: 1'b1, kind: k, op: op, dest: t, src1: s1, src2: s2};
        if (record) begin
            pending[t]    = 1'b1;
            exp_value[t]  = result_of(op, v1, v2);
            disp_cycle[t] = cycle;
            is_mult[t]    = (k == kind_mult);
            dep1[t]       = d1;
            dep2[t]       = d2;
            prod1[t]      = p1;
            prod2[t]      = p2;
            last_tag      = t;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        fu_kind_t k;
        logic     room;
        seed     = 32'h620f;
        reset    = 1'b1;
        squash   = 1'b0;
        dispatch = '0;
        last_cdb = '0;
        next_tag = '0;
        last_tag = '0;
        clear_all();
        repeat (2) @(posedge clock);
        #10;
        reset = 1'b0;
        for (int step = 0; step < steps; step++) begin
            @(posedge clock);
            #10;
            retire(last_cdb);
            if (squash) begin
                squash = 1'b0;
                clear_all();
            end
            count_accepted();
            dispatch.valid = 1'b0;
            if (step % 100 == 60) begin
                squash = 1'b1;
            end else if (($random(seed) & 7) != 0) begin
                k    = fu_kind_t'($random(seed) & 1);
                room = (k == kind_mult) ? mult_count < num_mult : alu_count < num_alu;
                if (room)
                    offer(k, 1'b1);
                else if ($random(seed) & 1)
                    offer(k, 1'b0);
            end
            last_cdb = cdb;
        end
        // drain, the last offer is counted on the first pass
        do begin
            @(posedge clock);
            #10;
            retire(last_cdb);
            count_accepted();
            dispatch.valid = 1'b0;
            last_cdb = cdb;
        end while (alu_count + mult_count != 0);
        repeat (2) @(posedge clock);
        if (failed) begin
            $display("SOME TESTS FAILED");
            $fatal(1, "run ended with errors");
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- sources.f
hw/fu_pkg.sv
hw/rs_pkg.sv
hw/alu_unit.sv
hw/mult_unit.sv
hw/rs_bank.sv
hw/cdb_arbiter.sv
hw/rs_top.sv
verif/tb_rs_checks.sv
verif/tb_rs.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_rs -f sources.f --Mdir obj_dir -o tb_rs_sim

./obj_dir/tb_rs_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
    exit 0
fi
exit 1
